/* rtl/aluPipe_defs.svh */
// widths fixed for the 8-bit datapath; REG_IDX_W must stay log2 of REG_CNT
`ifndef ALU_PIPE_DEFS_SVH
`define ALU_PIPE_DEFS_SVH

// datapath
`define DATA_W     8    // operand and result width
`define INSTR_W    16   // one instruction word per transfer

// register file
`define REG_CNT    8    // uniform file, no address registers
`define REG_IDX_W  3    // low bits of each 4-bit register field

// decode
`define OPCODE_W   4    // top nibble of the word
`define FLAG_W     4    // zero, carry, negative, overflow

`endif

/* rtl/aluPipePkg.sv */
// opcodes 0 and 15 are reserved; register fields are 4 bits but only the low 3 index the file
`include "aluPipe_defs.svh"

package aluPipePkg;

    // 4-bit opcode in the top nibble of every word
    typedef enum logic [`OPCODE_W-1:0] {
        OP_RSV0  = 4'd0,  // accepted and dropped
        OP_LDI   = 4'd1,  // immediate form
        OP_ADC   = 4'd2,
        OP_MOV   = 4'd3,
        OP_AND   = 4'd4,
        OP_OR    = 4'd5,
        OP_NOT   = 4'd6,
        OP_ADD   = 4'd7,
        OP_SUB   = 4'd8,
        OP_LSR   = 4'd9,
        OP_LSL   = 4'd10,
        OP_ROL   = 4'd11, // through carry
        OP_ROR   = 4'd12, // through carry
        OP_INC   = 4'd13,
        OP_DEC   = 4'd14,
        OP_RSV15 = 4'd15  // accepted and dropped
    } opcode_e;

    typedef struct packed {
        opcode_e    opcode;
        logic [3:0] dest;
        logic [3:0] src1;   // operand A
        logic [3:0] src2;   // operand B
    } regView_t;

    typedef struct packed {
        opcode_e    opcode;
        logic [3:0] dest;
        logic [7:0] imm;    // goes out on operand B
    } immView_t;

    // same 16 bits, two decodings
    typedef union packed {
        regView_t regView;
        immView_t immView;
    } instrWord_u;

    typedef struct packed {
        logic zero;     // msb
        logic carry;
        logic negative;
        logic overflow; // lsb
    } flags_t;

endpackage

/* rtl/stageIf.sv */
// one decoded op per transfer; source holds everything stable until ready
`timescale 1ns/1ps
`include "aluPipe_defs.svh"

interface stageIf import aluPipePkg::*; ();

    logic                  valid;  // decode register occupied
    logic                  ready;  // execute can take it this edge
    opcode_e               op;
    logic [`REG_IDX_W-1:0] dest;   // write-back index
    logic [`DATA_W-1:0]    opA;    // src1 value
    logic [`DATA_W-1:0]    opB;    // src2 value or immediate

    // decode side
    modport source (
        output valid, op, dest, opA, opB,
        input  ready
    );

    // execute side
    modport sink (
        input  valid, op, dest, opA, opB,
        output ready
    );

endinterface

/* rtl/regFile.sv */
// reads are combinational and bypass a same-cycle write; this is the only forwarding path
`timescale 1ns/1ps
`include "aluPipe_defs.svh"

module regFile (
    input  logic                  CLK,
    input  logic                  rst_i,
    input  logic [`REG_IDX_W-1:0] rdIdxA_i,
    input  logic [`REG_IDX_W-1:0] rdIdxB_i,
    input  logic                  wrEn_i,
    input  logic [`REG_IDX_W-1:0] wrIdx_i,
    input  logic [`DATA_W-1:0]    wrData_i,
    output logic [`DATA_W-1:0]    rdDataA_o,
    output logic [`DATA_W-1:0]    rdDataB_o
);

    logic [`DATA_W-1:0] regs [`REG_CNT];  // r0..r7, no special registers
    logic               hitA;             // port A reads the reg being written
    logic               hitB;

    always_ff @(posedge CLK) begin
        if (rst_i) begin
            for (int i = 0; i < `REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn_i) begin
            regs[wrIdx_i] <= wrData_i;            // single write port
        end
    end

    assign hitA = wrEn_i && (wrIdx_i == rdIdxA_i);
    assign hitB = wrEn_i && (wrIdx_i == rdIdxB_i);

    // write-through so a back-to-back dependent op sees the new value
    assign rdDataA_o = hitA ? wrData_i : regs[rdIdxA_i];
    assign rdDataB_o = hitB ? wrData_i : regs[rdIdxB_i];

    // write index comes from the execute stage, must be known when used
    wrIdxKnown_a: assert property (
        @(posedge CLK) disable iff (rst_i)
        wrEn_i |-> !$isunknown(wrIdx_i)
    );

endmodule

/* rtl/decodeStage.sv */
// operands are sampled at acceptance; correct only because the file bypasses the write of that edge
`timescale 1ns/1ps
`include "aluPipe_defs.svh"

module decodeStage import aluPipePkg::*; (
    input  logic                  CLK,
    input  logic                  rst_i,
    input  instrWord_u            instr_i,
    input  logic                  instrValid_i,
    output logic                  instrReady_o,
    output logic [`REG_IDX_W-1:0] rdIdxA_o,
    output logic [`REG_IDX_W-1:0] rdIdxB_o,
    input  logic [`DATA_W-1:0]    rdDataA_i,
    input  logic [`DATA_W-1:0]    rdDataB_i,
    stageIf.source                sIf
);

    logic               accept;   // input transfer this edge
    logic               opUsed;   // opcode maps to an ALU op
    logic               isLdi;    // immediate view applies
    opcode_e            opcode;
    logic [`DATA_W-1:0] opBSel;   // register B or immediate

    // opcode sits in the same place in both views
    assign opcode = instr_i.regView.opcode;
    assign isLdi  = (opcode == OP_LDI);
    assign opUsed = (opcode != OP_RSV0) && (opcode != OP_RSV15);

    // register view for the source fields, bit 3 dropped
    assign rdIdxA_o = instr_i.regView.src1[`REG_IDX_W-1:0];
    assign rdIdxB_o = instr_i.regView.src2[`REG_IDX_W-1:0];

    // LDI reads the low byte as data instead of src1/src2
    assign opBSel = isLdi ? instr_i.immView.imm : rdDataB_i;

    // empty, or draining into execute on this edge
    assign instrReady_o = !sIf.valid || sIf.ready;
    assign accept       = instrValid_i && instrReady_o;

    // occupancy flag
    always_ff @(posedge CLK) begin
        if (rst_i) begin
            sIf.valid <= 1'b0;
        end else if (instrReady_o) begin
            sIf.valid <= instrValid_i && opUsed;  // reserved ops vanish here
        end
    end

    // payload, loaded on every input transfer
    always_ff @(posedge CLK) begin
        if (accept) begin
            sIf.op   <= opcode;
            sIf.dest <= instr_i.regView.dest[`REG_IDX_W-1:0];
            sIf.opA  <= rdDataA_i;
            sIf.opB  <= opBSel;
        end
    end

    // reserved opcodes must never reach the ALU
    noReservedOp_a: assert property (
        @(posedge CLK) disable iff (rst_i)
        sIf.valid |-> !(sIf.op inside {OP_RSV0, OP_RSV15})
    );

endmodule

/* rtl/aluCore.sv */
// purely combinational; flags_i is the committed flag state, flags_o its next value
`timescale 1ns/1ps
`include "aluPipe_defs.svh"

module aluCore import aluPipePkg::*; (
    input  opcode_e            op_i,
    input  logic [`DATA_W-1:0] opA_i,
    input  logic [`DATA_W-1:0] opB_i,
    input  flags_t             flags_i,
    output logic [`DATA_W-1:0] result_o,
    output flags_t             flags_o
);

    localparam int MSB = `DATA_W - 1;

    logic [`DATA_W-1:0] addB;     // second adder input
    logic               addCin;   // adder carry in
    logic [`DATA_W:0]   sum;      // carry out in the top bit
    logic               addOvf;   // signed overflow of the adder
    logic [`DATA_W-1:0] res;
    logic               carryNext;
    logic               ovfNext;

    // one adder covers ADD, ADC, SUB, INC and DEC
    always_comb begin
        case (op_i)
            OP_ADC: begin
                addB   = opB_i;
                addCin = flags_i.carry;       // chained add
            end
            OP_SUB: begin
                addB   = ~opB_i;              // A + ~B + 1
                addCin = 1'b1;
            end
            OP_INC: begin
                addB   = '0;
                addCin = 1'b1;
            end
            OP_DEC: begin
                addB   = '1;                  // add minus one
                addCin = 1'b0;
            end
            default: begin
                addB   = opB_i;               // plain ADD
                addCin = 1'b0;
            end
        endcase
    end

    assign sum    = {1'b0, opA_i} + {1'b0, addB} + `DATA_W'(addCin);
    assign addOvf = (opA_i[MSB] == addB[MSB]) && (sum[MSB] != opA_i[MSB]);

    always_comb begin
        res       = '0;
        carryNext = flags_i.carry;            // held unless the op defines it
        ovfNext   = 1'b0;
        case (op_i)
            OP_LDI: res = opB_i;              // immediate already on B
            OP_MOV: res = opA_i;
            OP_NOT: res = ~opA_i;
            OP_AND: res = opA_i & opB_i;
            OP_OR:  res = opA_i | opB_i;
            OP_ADD, OP_ADC: begin
                res       = sum[MSB:0];
                carryNext = sum[`DATA_W];
                ovfNext   = addOvf;
            end
            OP_SUB: begin
                res       = sum[MSB:0];
                carryNext = !sum[`DATA_W];    // borrow when A < B
                ovfNext   = addOvf;
            end
            OP_INC, OP_DEC: begin
                res     = sum[MSB:0];         // carry untouched
                ovfNext = addOvf;
            end
            OP_LSL: begin
                res       = {opA_i[MSB-1:0], 1'b0};
                carryNext = opA_i[MSB];
            end
            OP_LSR: begin
                res       = {1'b0, opA_i[MSB:1]};
                carryNext = opA_i[0];
            end
            OP_ROL: begin
                res       = {opA_i[MSB-1:0], flags_i.carry};
                carryNext = opA_i[MSB];
            end
            OP_ROR: begin
                res       = {flags_i.carry, opA_i[MSB:1]};
                carryNext = opA_i[0];
            end
            default: res = '0;                // reserved, filtered in decode
        endcase
    end

    assign result_o          = res;
    assign flags_o.zero      = (res == '0);
    assign flags_o.carry     = carryNext;
    assign flags_o.negative  = res[MSB];
    assign flags_o.overflow  = ovfNext;

endmodule

/* rtl/executeStage.sv */
// commit happens on the stageIf transfer; a stalled output register also stalls write-back
`timescale 1ns/1ps
`include "aluPipe_defs.svh"

module executeStage import aluPipePkg::*; (
    input  logic                  CLK,
    input  logic                  rst_i,
    stageIf.sink                  sIf,
    output logic                  wrEn_o,
    output logic [`REG_IDX_W-1:0] wrIdx_o,
    output logic [`DATA_W-1:0]    wrData_o,
    output logic                  resultValid_o,
    output logic [`DATA_W-1:0]    resultData_o,
    output logic [`REG_IDX_W-1:0] resultDest_o,
    output flags_t                resultFlags_o,
    input  logic                  resultReady_i
);

    flags_t             flagReg;   // architectural flags
    flags_t             aluFlags;
    logic [`DATA_W-1:0] aluRes;
    logic               xfer;      // decode hands over an op

    aluCore u_aluCore (
        .op_i     (sIf.op),
        .opA_i    (sIf.opA),
        .opB_i    (sIf.opB),
        .flags_i  (flagReg),
        .result_o (aluRes),
        .flags_o  (aluFlags)
    );

    // output register empty or leaving this edge
    assign sIf.ready = !resultValid_o || resultReady_i;
    assign xfer      = sIf.valid && sIf.ready;

    // write-back lands on the same edge as the output load
    assign wrEn_o   = xfer;
    assign wrIdx_o  = sIf.dest;
    assign wrData_o = aluRes;

    always_ff @(posedge CLK) begin
        if (rst_i) begin
            flagReg       <= '0;
            resultValid_o <= 1'b0;
        end else begin
            if (xfer) begin
                flagReg <= aluFlags;           // next op sees these
            end
            if (sIf.ready) begin
                resultValid_o <= sIf.valid;    // bubble when decode is empty
            end
        end
    end

    // result payload
    always_ff @(posedge CLK) begin
        if (xfer) begin
            resultData_o  <= aluRes;
            resultDest_o  <= sIf.dest;
            resultFlags_o <= aluFlags;
        end
    end

    // held result must not change or drop under back-pressure
    outHold_a: assert property (
        @(posedge CLK) disable iff (rst_i)
        (resultValid_o && !resultReady_i) |=>
            resultValid_o && $stable(resultData_o) && $stable(resultDest_o)
            && $stable(resultFlags_o)
    );

endmodule

/* rtl/aluPipeTop.sv */
// two-stage pipe, result two edges after acceptance; reserved opcodes give no result
`timescale 1ns/1ps
`include "aluPipe_defs.svh"

module aluPipeTop (
    input  logic                  CLK,
    input  logic                  rst_i,
    input  logic [`INSTR_W-1:0]   instr_i,
    input  logic                  instrValid_i,
    output logic                  instrReady_o,
    output logic                  resultValid_o,
    output logic [`DATA_W-1:0]    resultData_o,
    output logic [`REG_IDX_W-1:0] resultDest_o,
    output logic [`FLAG_W-1:0]    resultFlags_o,
    input  logic                  resultReady_i
);

    logic [`REG_IDX_W-1:0] rdIdxA;
    logic [`REG_IDX_W-1:0] rdIdxB;
    logic [`DATA_W-1:0]    rdDataA;
    logic [`DATA_W-1:0]    rdDataB;
    logic                  wrEn;
    logic [`REG_IDX_W-1:0] wrIdx;
    logic [`DATA_W-1:0]    wrData;

    stageIf u_stageIf ();   // decode to execute

    regFile u_regFile (
        .CLK       (CLK),
        .rst_i     (rst_i),
        .rdIdxA_i  (rdIdxA),
        .rdIdxB_i  (rdIdxB),
        .wrEn_i    (wrEn),
        .wrIdx_i   (wrIdx),
        .wrData_i  (wrData),
        .rdDataA_o (rdDataA),
        .rdDataB_o (rdDataB)
    );

    decodeStage u_decodeStage (
        .CLK          (CLK),
        .rst_i        (rst_i),
        .instr_i      (instr_i),        // raw word, decoded as the union
        .instrValid_i (instrValid_i),
        .instrReady_o (instrReady_o),
        .rdIdxA_o     (rdIdxA),
        .rdIdxB_o     (rdIdxB),
        .rdDataA_i    (rdDataA),
        .rdDataB_i    (rdDataB),
        .sIf          (u_stageIf.source)
    );

    executeStage u_executeStage (
        .CLK           (CLK),
        .rst_i         (rst_i),
        .sIf           (u_stageIf.sink),
        .wrEn_o        (wrEn),
        .wrIdx_o       (wrIdx),
        .wrData_o      (wrData),
        .resultValid_o (resultValid_o),
        .resultData_o  (resultData_o),
        .resultDest_o  (resultDest_o),
        .resultFlags_o (resultFlags_o),  // zero, carry, negative, overflow
        .resultReady_i (resultReady_i)
    );

endmodule

/* dv/tbClock.sv */
// free-running 10 ns clock; reset is high for the first four rising edges and drops on a falling edge
`timescale 1ns/1ps

module tbClock (
    output logic CLK,
    output logic rst_o
);

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;          // 10 ns period
    end

    initial begin
        rst_o = 1'b1;
        repeat (4) @(posedge CLK);      // four reset cycles
        @(negedge CLK);
        rst_o = 1'b0;                   // away from the sampling edge
    end

endmodule

/* dv/aluPipeTb.sv */
// 2000 random words with a fixed seed; inputs change on falling edges, outputs sampled on rising
`timescale 1ns/1ps
`include "aluPipe_defs.svh"

module aluPipeTb import aluPipePkg::*; ();

    localparam int NUM_INSTR   = 2000;
    localparam int CYCLE_LIMIT = NUM_INSTR * 8 + 200;

    logic                  CLK;
    logic                  rst;
    logic [`INSTR_W-1:0]   instr;
    logic                  instrValid;
    logic                  instrReady;
    logic                  resultValid;
    logic [`DATA_W-1:0]    resultData;
    logic [`REG_IDX_W-1:0] resultDest;
    logic [`FLAG_W-1:0]    resultFlags;
    logic                  resultReady;

    logic [`DATA_W-1:0]    mRegs [`REG_CNT];   // model register file
    logic [`FLAG_W-1:0]    mFlags;             // {zero, carry, negative, overflow}
    logic [`DATA_W-1:0]    expData [$];
    logic [`REG_IDX_W-1:0] expDest [$];
    logic [`FLAG_W-1:0]    expFlags [$];
    int                    expCycle [$];       // acceptance cycle per result
    logic [31:0]           rngState = 32'hf7c3;
    logic                  inXfer;             // input transfer at last rising edge
    logic                  holdPending;        // output held at last rising edge
    logic [14:0]           heldWord;
    logic                  burst;
    logic                  driving;
    int                    cycleCnt;
    int                    issued;
    int                    outCnt;
    int                    lastLatency;
    int                    dataErr;
    int                    destErr;
    int                    flagErr;
    int                    protoErr;

    tbClock u_tbClock (.CLK(CLK), .rst_o(rst));

    aluPipeTop i_dut (
        .CLK           (CLK),
        .rst_i         (rst),
        .instr_i       (instr),
        .instrValid_i  (instrValid),
        .instrReady_o  (instrReady),
        .resultValid_o (resultValid),
        .resultData_o  (resultData),
        .resultDest_o  (resultDest),
        .resultFlags_o (resultFlags),
        .resultReady_i (resultReady)
    );

    function automatic logic [31:0] nextRand(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // returns {flags, result} from integer arithmetic
    function automatic logic [11:0] modelAlu(input logic [3:0] op, input logic [7:0] a,
                                             input logic [7:0] b, input logic [3:0] fIn);
        int         sA;
        int         sB;
        int         wide;     // unsigned sum or difference
        int         sgn;      // signed sum or difference
        int         cin;
        logic       c;
        logic       v;
        logic [7:0] r;
        sA   = int'($signed(a));
        sB   = int'($signed(b));
        cin  = (op == OP_ADC) ? int'(fIn[2]) : 0;
        c    = fIn[2];        // carry kept unless the op sets it
        v    = 1'b0;
        case (op)
            OP_LDI: r = b;
            OP_MOV: r = a;
            OP_NOT: r = ~a;
            OP_AND: r = a & b;
            OP_OR:  r = a | b;
            OP_ADD, OP_ADC: begin
                wide = int'(a) + int'(b) + cin;
                sgn  = sA + sB + cin;
                r    = 8'(wide);
                c    = (wide > 255);
                v    = (sgn > 127) || (sgn < -128);
            end
            OP_SUB: begin
                sgn = sA - sB;
                r   = 8'(int'(a) - int'(b));
                c   = (a < b);                  // borrow
                v   = (sgn > 127) || (sgn < -128);
            end
            OP_INC: begin
                r = 8'(int'(a) + 1);
                v = (sA + 1 > 127);
            end
            OP_DEC: begin
                r = 8'(int'(a) - 1);
                v = (sA - 1 < -128);
            end
            OP_LSL: begin
                r = a << 1;
                c = a[7];
            end
            OP_LSR: begin
                r = a >> 1;
                c = a[0];
            end
            OP_ROL: begin
                r = {a[6:0], fIn[2]};
                c = a[7];
            end
            OP_ROR: begin
                r = {fIn[2], a[7:1]};
                c = a[0];
            end
            default: r = 8'h00;
        endcase
        return {(r == 8'h00), c, r[7], v, r};
    endfunction

    // applies one accepted word to the model and queues what should come out
    task automatic applyModel(input logic [15:0] w);
        logic [3:0]  op;
        logic [7:0]  b;
        logic [11:0] res;
        op = w[15:12];
        if (op != 4'd0 && op != 4'd15) begin       // reserved words leave no trace
            b   = (op == OP_LDI) ? w[7:0] : mRegs[w[2:0]];
            res = modelAlu(op, mRegs[w[6:4]], b, mFlags);
            mRegs[w[10:8]] = res[7:0];
            mFlags         = res[11:8];
            expData.push_back(res[7:0]);
            expDest.push_back(w[10:8]);
            expFlags.push_back(res[11:8]);
            expCycle.push_back(cycleCnt);
        end
    endtask

    task automatic checkResult();
        logic [7:0] eD;
        logic [2:0] eDst;
        logic [3:0] eF;
        if (expData.size() == 0) begin
            $display("result seen at cycle %0d with no instruction pending", cycleCnt);
            protoErr++;
        end else begin
            eD          = expData.pop_front();
            eDst        = expDest.pop_front();
            eF          = expFlags.pop_front();
            lastLatency = cycleCnt - expCycle.pop_front();
            if (resultData !== eD) begin
                $display("[FAIL] resultData_o exp 0x%02h got 0x%02h", eD, resultData);
                dataErr++;
            end
            if (resultDest !== eDst) begin
                $display("[FAIL] resultDest_o exp 0x%0h got 0x%0h", eDst, resultDest);
                destErr++;
            end
            if (resultFlags !== eF) begin
                $display("[FAIL] resultFlags_o exp 0x%0h got 0x%0h", eF, resultFlags);
                flagErr++;
            end
            outCnt++;
        end
    endtask

    // both handshakes sampled on the rising edge
    always @(posedge CLK) begin
        cycleCnt++;
        if (rst) begin
            inXfer      = 1'b0;
            holdPending = 1'b0;
        end else begin
            inXfer = instrValid && instrReady;
            if (inXfer) begin
                applyModel(instr);
            end
            if (holdPending) begin
                if (resultValid !== 1'b1) begin
                    $display("held result was dropped at cycle %0d", cycleCnt);
                    protoErr++;
                end else if ({resultData, resultDest, resultFlags} !== heldWord) begin
                    $write("[FAIL] held {resultData_o,resultDest_o,resultFlags_o} ");
                    $display("exp 0x%04h got 0x%04h", heldWord,
                             {resultData, resultDest, resultFlags});
                    protoErr++;
                end
            end
            if (resultValid && resultReady) begin
                checkResult();
            end
            holdPending = resultValid && !resultReady;
            heldWord    = {resultData, resultDest, resultFlags};
        end
    end

    initial begin
        wait (cycleCnt >= CYCLE_LIMIT);
        $display("timeout after %0d cycles, %0d of %0d words issued", cycleCnt, issued, NUM_INSTR);
        $display("errors: data %0d, dest %0d, flags %0d, protocol %0d", dataErr, destErr,
                 flagErr, protoErr + 1);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        instr       = '0;
        instrValid  = 1'b0;
        resultReady = 1'b0;
        inXfer      = 1'b0;
        holdPending = 1'b0;
        mFlags      = '0;
        for (int i = 0; i < `REG_CNT; i++) begin
            mRegs[i] = '0;                          // reset state of the file
        end
        @(negedge rst);
        @(negedge CLK);
        if (resultValid !== 1'b0) begin
            $display("[FAIL] resultValid_o after reset exp 0x0 got 0x%0h", resultValid);
            protoErr++;
        end
        if (instrReady !== 1'b1) begin
            $display("[FAIL] instrReady_o after reset exp 0x1 got 0x%0h", instrReady);
            protoErr++;
        end
        instr       = {OP_MOV, 4'd5, 4'd3, 4'd0};   // lone MOV r5, r3 on a cleared file
        instrValid  = 1'b1;
        resultReady = 1'b1;
        do @(negedge CLK); while (!inXfer);
        instrValid = 1'b0;
        while (outCnt < 1) @(negedge CLK);
        if (lastLatency != 2) begin
            $display("[FAIL] resultValid_o transfer latency exp 0x2 got 0x%0h", lastLatency);
            protoErr++;
        end
        issued  = 0;
        driving = 1'b1;
        while (driving) begin
            @(negedge CLK);
            rngState    = nextRand(rngState);
            burst       = ((issued / 64) % 2) == 1;   // back-to-back without back-pressure
            resultReady = burst ? 1'b1 : (rngState[1:0] != 2'b00);
            if (!instrValid || inXfer) begin
                if (issued == NUM_INSTR) begin
                    instrValid = 1'b0;
                    driving    = 1'b0;
                end else if (burst || rngState[4:2] != 3'b000) begin
                    instr      = rngState[31:16];
                    instrValid = 1'b1;
                    issued++;
                end else begin
                    instrValid = 1'b0;                // idle gap
                end
            end
        end
        resultReady = 1'b1;
        repeat (10) @(negedge CLK);                   // drain both stages
        if (expData.size() != 0) begin
            $display("run ended with %0d results never delivered", expData.size());
            protoErr++;
        end
        $display("errors: data %0d, dest %0d, flags %0d, protocol %0d (%0d results checked)",
                 dataErr, destErr, flagErr, protoErr, outCnt);
        if (dataErr + destErr + flagErr + protoErr == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+rtl
rtl/aluPipePkg.sv
rtl/stageIf.sv
rtl/regFile.sv
rtl/decodeStage.sv
rtl/aluCore.sv
rtl/executeStage.sv
rtl/aluPipeTop.sv
dv/tbClock.sv
dv/aluPipeTb.sv
